/* source/rv_m_pkg.sv */
// M extension shared definitions

package rv_m_pkg;

    // =========================================================================
    // funct3 codes of the M extension
    // =========================================================================
    localparam logic [2:0] funct_mul    = 3'b000; // Low half of the product.
    localparam logic [2:0] funct_mulh   = 3'b001; // High half, both operands signed.
    localparam logic [2:0] funct_mulhsu = 3'b010; // High half, signed times unsigned.
    localparam logic [2:0] funct_mulhu  = 3'b011; // High half, both unsigned.
    localparam logic [2:0] funct_div    = 3'b100; // Signed quotient.
    localparam logic [2:0] funct_divu   = 3'b101; // Unsigned quotient.
    localparam logic [2:0] funct_rem    = 3'b110; // Signed remainder.
    localparam logic [2:0] funct_remu   = 3'b111; // Unsigned remainder.

    // Operand width used when the top level does not override it.
    localparam int xlen_default = 32;

    // The restoring divider retires one quotient bit per step.
    // So it needs exactly as many steps as the operand has bits.
    function automatic int div_steps(input int width);
        return width;
    endfunction

endpackage

/* source/m_op_if.sv */
// Decoded operation bus
`timescale 1ns/1ps

interface m_op_if #(
    parameter int xlen = rv_m_pkg::xlen_default
);
    logic            mul_go;      // One-cycle start of the multiply unit.
    logic            div_go;      // One-cycle start of the divide unit.
    logic            high;        // Return the upper product half.
    logic            src1_signed; // Operand 1 is two's complement.
    logic            src2_signed; // Operand 2 is two's complement.
    logic            rem;         // Return the remainder, not the quotient.
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;

    // The decode stage owns every signal on the bus.
    modport decode (
        output mul_go, div_go, high, src1_signed, src2_signed, rem, src1, src2
    );

    // The multiplier has no use for the remainder select.
    modport mul (
        input mul_go, high, src1_signed, src2_signed, src1, src2
    );

    // The divider ignores the product half select.
    modport div (
        input div_go, src1_signed, src2_signed, rem, src1, src2
    );

endinterface

/* source/m_decode.sv */
// M extension decode stage
`timescale 1ns/1ps

module m_decode #(
    parameter int xlen = rv_m_pkg::xlen_default
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            flush,
    input  logic            busy,
    input  logic            start,
    input  logic [2:0]      funct3,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    m_op_if.decode          op
);
    import rv_m_pkg::*;

    logic accept;   // Start taken at the coming edge.
    logic is_div;   // Operation goes to the divider.
    logic dec_high;
    logic dec_s1;
    logic dec_s2;
    logic dec_rem;

    // =========================================================================
    // funct3 decode
    // =========================================================================
    always_comb begin
        // A divide that sits on the bus but has not loaded yet also blocks.
        accept = start && !busy && !op.div_go && !stall;

        is_div   = 1'b0;
        dec_high = 1'b0;
        dec_s1   = 1'b0;
        dec_s2   = 1'b0;
        dec_rem  = 1'b0;
        case (funct3)
            funct_mul:    dec_high = 1'b0; // Low half is the same for any signedness.
            funct_mulh: begin
                dec_high = 1'b1;
                dec_s1   = 1'b1;
                dec_s2   = 1'b1;
            end
            funct_mulhsu: begin
                dec_high = 1'b1;
                dec_s1   = 1'b1; // Only operand 1 is signed here.
            end
            funct_mulhu:  dec_high = 1'b1;
            funct_div: begin
                is_div = 1'b1;
                dec_s1 = 1'b1;
                dec_s2 = 1'b1;
            end
            funct_divu:   is_div = 1'b1;
            funct_rem: begin
                is_div  = 1'b1;
                dec_s1  = 1'b1;
                dec_s2  = 1'b1;
                dec_rem = 1'b1;
            end
            funct_remu: begin
                is_div  = 1'b1;
                dec_rem = 1'b1;
            end
            default:      is_div = 1'b0;
        endcase
    end

    // The go strobes last one cycle unless a stall holds them.
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            op.mul_go <= 1'b0;
            op.div_go <= 1'b0;
        end else if (!stall) begin
            op.mul_go <= accept && !is_div;
            op.div_go <= accept && is_div;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op.high        <= dec_high;
            op.src1_signed <= dec_s1;
            op.src2_signed <= dec_s2;
            op.rem         <= dec_rem;
            op.src1        <= src1;
            op.src2        <= src2;
        end
    end

    // The core must wait for the divider to go idle before the next start.
    start_while_busy: assert property (@(posedge clk) disable iff (reset || flush)
        start |-> !busy)
        else $warning("Start raised while the divider is busy, the start is dropped.");

    funct3_known: assert property (@(posedge clk) disable iff (reset)
        start |-> !$isunknown(funct3))
        else $error("funct3 has unknown bits at start.");

endmodule

/* source/mul_unit.sv */
// One-cycle multiply unit
`timescale 1ns/1ps

module mul_unit #(
    parameter int xlen = rv_m_pkg::xlen_default
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            flush,
    m_op_if.mul             op,
    output logic            done,
    output logic [xlen-1:0] result
);
    logic                    sign1;
    logic                    sign2;
    logic [xlen:0]           ext1;    // Operand 1 widened by its sign bit.
    logic [xlen:0]           ext2;
    logic signed [2*xlen+1:0] product;

    // The product register is the one in the result stage, so the product is
    // handed over in the cycle that its go is on the bus.
    always_comb begin
        sign1 = op.src1_signed && op.src1[xlen-1];
        sign2 = op.src2_signed && op.src2[xlen-1];
        ext1  = {sign1, op.src1};
        ext2  = {sign2, op.src2};

        // One extra bit per operand makes every mix a plain signed multiply.
        product = $signed(ext1) * $signed(ext2);

        done   = op.mul_go;
        result = op.high ? product[2*xlen-1:xlen] : product[xlen-1:0];
    end

    // The operation must stay on the bus while a stall keeps the result
    // stage from taking the product.
    go_held_in_stall: assert property (@(posedge clk) disable iff (reset || flush)
        (op.mul_go && stall) |=> op.mul_go)
        else $error("Multiply go dropped during a stall.");

endmodule

/* source/div_unit.sv */
// Iterative restoring divider
`timescale 1ns/1ps

module div_unit #(
    parameter int xlen = rv_m_pkg::xlen_default
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            flush,
    m_op_if.div             op,
    output logic            busy,
    output logic            done,
    output logic [xlen-1:0] result
);
    import rv_m_pkg::*;

    localparam int steps   = div_steps(xlen);
    localparam int count_w = $clog2(steps);
    localparam logic [count_w-1:0] last = count_w'(steps - 1);

    logic               run;      // Shift-subtract steps remain.
    logic [count_w-1:0] count;    // Steps already done.
    logic [xlen-1:0]    quo;      // Dividend shifting out, quotient shifting in.
    logic [xlen-1:0]    part_rem; // Partial remainder.
    logic [xlen-1:0]    divisor;  // Divisor magnitude.
    logic               neg_q;
    logic               neg_r;
    logic               want_rem;
    logic               div_zero;

    logic [xlen-1:0] mag1;
    logic [xlen-1:0] mag2;
    logic [xlen:0]   shifted;
    logic [xlen:0]   diff;
    logic [xlen-1:0] step_quo;
    logic [xlen-1:0] step_rem;
    logic [xlen-1:0] fin_quo;
    logic [xlen-1:0] fin_rem;

    always_comb begin
        // The most negative value keeps its bit pattern, which is its
        // correct unsigned magnitude.
        mag1 = (op.src1_signed && op.src1[xlen-1]) ? -op.src1 : op.src1;
        mag2 = (op.src2_signed && op.src2[xlen-1]) ? -op.src2 : op.src2;

        // =====================================================================
        // One restoring step
        // =====================================================================
        shifted  = {part_rem, quo[xlen-1]};
        diff     = shifted - {1'b0, divisor};
        step_rem = diff[xlen] ? shifted[xlen-1:0] : diff[xlen-1:0]; // Restore on borrow.
        step_quo = {quo[xlen-2:0], ~diff[xlen]};

        // Zero divisor gives all ones, remainder keeps the dividend.
        // The overflow case comes out of the magnitudes by itself.
        fin_quo = div_zero ? '1 : (neg_q ? -step_quo : step_quo);
        fin_rem = neg_r ? -step_rem : step_rem;

        // Forward the final step so the result stage registers it at once.
        done   = run && (count == last);
        result = want_rem ? fin_rem : fin_quo;
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            run   <= 1'b0;
            busy  <= 1'b0;
            count <= '0;
        end else if (!stall) begin
            if (op.div_go) begin
                run   <= 1'b1;
                busy  <= 1'b1;
                count <= '0;
            end else if (run) begin
                count <= count + 1'b1;
                if (count == last) run <= 1'b0; // Busy stays up one more cycle.
            end else begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (op.div_go) begin
                quo      <= mag1;
                part_rem <= '0;
                divisor  <= mag2;
                neg_q    <= (op.src1_signed && op.src1[xlen-1]) ^
                            (op.src2_signed && op.src2[xlen-1]);
                neg_r    <= op.src1_signed && op.src1[xlen-1]; // Follows the dividend.
                want_rem <= op.rem;
                div_zero <= (op.src2 == '0);
            end else if (run) begin
                quo      <= step_quo;
                part_rem <= step_rem;
            end
        end
    end

    // Decode has to hold back starts until the previous divide retires.
    go_while_busy: assert property (@(posedge clk) disable iff (reset || flush)
        op.div_go |-> !busy)
        else $error("Divide go arrived while the divider is busy.");

endmodule

/* source/m_result.sv */
// M extension result stage
`timescale 1ns/1ps

module m_result #(
    parameter int xlen = rv_m_pkg::xlen_default
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            flush,
    input  logic            mul_done,
    input  logic            div_done,
    input  logic [xlen-1:0] mul_result,
    input  logic [xlen-1:0] div_result,
    output logic            done,
    output logic [xlen-1:0] result
);
    // Both units hand over next-state completions, so this flop is the
    // last register of each unit's latency.
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            done   <= 1'b0;
            result <= '0;
        end else if (!stall) begin
            done <= mul_done || div_done;
            if (mul_done || div_done) begin
                result <= div_done ? div_result : mul_result;
            end
        end
    end

    // A divide blocks later starts, so completions never collide.
    one_completion: assert property (@(posedge clk) disable iff (reset || flush)
        !(mul_done && div_done))
        else $error("Multiply and divide completed in the same cycle.");

endmodule

/* source/m_ext_top.sv */
// M extension execute block
`timescale 1ns/1ps

module m_ext_top #(
    parameter int xlen = rv_m_pkg::xlen_default
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  logic [2:0]      funct3,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    input  logic            stall,
    input  logic            flush,
    output logic            busy,
    output logic            done,
    output logic [xlen-1:0] result
);
    logic            mul_done;
    logic            div_done;
    logic [xlen-1:0] mul_result;
    logic [xlen-1:0] div_result;

    m_op_if #(.xlen(xlen)) op_bus ();

    m_decode #(.xlen(xlen)) decode_i (
        .clk    (clk),
        .reset  (reset),
        .stall  (stall),
        .flush  (flush),
        .busy   (busy),
        .start  (start),
        .funct3 (funct3),
        .src1   (src1),
        .src2   (src2),
        .op     (op_bus.decode)
    );

    mul_unit #(.xlen(xlen)) mul_i (
        .clk    (clk),
        .reset  (reset),
        .stall  (stall),
        .flush  (flush),
        .op     (op_bus.mul),
        .done   (mul_done),
        .result (mul_result)
    );

    // The divider's busy level goes to the core and back into decode.
    div_unit #(.xlen(xlen)) div_i (
        .clk    (clk),
        .reset  (reset),
        .stall  (stall),
        .flush  (flush),
        .op     (op_bus.div),
        .busy   (busy),
        .done   (div_done),
        .result (div_result)
    );

    m_result #(.xlen(xlen)) result_i (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .flush      (flush),
        .mul_done   (mul_done),
        .div_done   (div_done),
        .mul_result (mul_result),
        .div_result (div_result),
        .done       (done),
        .result     (result)
    );

endmodule

/* include/m_ref_model.svh */
// Reference model for M operations
`ifndef M_REF_MODEL_SVH
`define M_REF_MODEL_SVH

// Full 64-bit product with each operand extended as funct3 asks.
function automatic logic [63:0] ref_product(input logic [2:0] funct3,
                                            input logic [31:0] a,
                                            input logic [31:0] b);
    logic        a_signed;
    logic        b_signed;
    logic [63:0] ea;
    logic [63:0] eb;
    a_signed = (funct3 == rv_m_pkg::funct_mulh) || (funct3 == rv_m_pkg::funct_mulhsu);
    b_signed = (funct3 == rv_m_pkg::funct_mulh);
    ea = a_signed ? {{32{a[31]}}, a} : {32'b0, a};
    eb = b_signed ? {{32{b[31]}}, b} : {32'b0, b};
    return ea * eb; // Low 64 bits are exact in two's complement.
endfunction

// Expected result word of one M operation.
function automatic logic [31:0] ref_result(input logic [2:0] funct3,
                                           input logic [31:0] a,
                                           input logic [31:0] b);
    logic        is_signed;
    logic [31:0] q;
    logic [31:0] r;
    logic [63:0] p;
    is_signed = (funct3 == rv_m_pkg::funct_div) || (funct3 == rv_m_pkg::funct_rem);
    p = ref_product(funct3, a, b);
    if (b == 32'd0) begin
        q = '1;
        r = a;
    end else if (is_signed && a == 32'h8000_0000 && b == '1) begin
        q = a; // Overflow keeps the dividend.
        r = '0;
    end else if (is_signed) begin
        q = $signed(a) / $signed(b); // Truncates toward zero.
        r = $signed(a) % $signed(b);
    end else begin
        q = a / b;
        r = a % b;
    end
    case (funct3)
        rv_m_pkg::funct_mul:                       return p[31:0];
        rv_m_pkg::funct_mulh, rv_m_pkg::funct_mulhsu,
        rv_m_pkg::funct_mulhu:                     return p[63:32];
        rv_m_pkg::funct_div, rv_m_pkg::funct_divu: return q;
        default:                                   return r;
    endcase
endfunction

`endif

/* tb/m_ext_tb.sv */
// M extension testbench
`timescale 1ns/1ps

module m_ext_tb;
    import rv_m_pkg::*;

    `include "m_ref_model.svh"

    localparam int xlen       = 32;
    localparam int clk_period = 4;
    localparam int n_ops      = 600;   // Starts the core gets accepted before draining.
    localparam int mul_lat    = 2;
    localparam int div_lat    = div_steps(xlen) + 2;
    // One divide latency per operation, half as much again for stalls, then reset and margin.
    localparam int timeout_cycles = n_ops * div_lat + n_ops * div_lat / 2 + 8 + 500;

    logic            clk;
    logic            reset;
    logic            start;
    logic [2:0]      funct3;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic            stall;
    logic            flush;
    logic            busy;
    logic            done;
    logic [xlen-1:0] result;

    // Scoreboard entries, one slot per accepted start in issue order.
    logic [xlen-1:0] exp_q[$];
    int              issue_q[$];      // Tick of the accepting edge.
    int              lat_q[$];
    string           name_q[$];
    string           op_names [8] = '{"MUL", "MULH", "MULHSU", "MULHU",
                                      "DIV", "DIVU", "REM", "REMU"};

    int              tick      = 0;   // Non-stalled edges since time zero.
    int              div_block = 0;   // Edges for which starts stay blocked by a divide.
    int              accepted  = 0;
    int              checked   = 0;
    int              errors    = 0;
    logic            idle_check = 1'b0;
    logic            hold_valid = 1'b0;
    logic [xlen-1:0] hold_value;

    m_ext_top #(.xlen(xlen)) dut_i (
        .clk(clk), .reset(reset), .start(start), .funct3(funct3), .src1(src1), .src2(src2),
        .stall(stall), .flush(flush), .busy(busy), .done(done), .result(result)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ========================================================================
    // Stimulus helpers
    // ========================================================================
    function automatic logic [xlen-1:0] pick_operand();
        case ($urandom_range(9))
            0: return '0;
            1: return 32'h0000_0001;
            2: return '1;              // Minus one.
            3: return 32'h8000_0000;   // Most negative value.
            4: return 32'h7fff_ffff;
            default: return $urandom();
        endcase
    endfunction

    task automatic drive_cycle();
        flush = ($urandom_range(249) == 0);
        stall = !flush && ($urandom_range(7) == 0);
        if (flush)
            start = 1'b0;
        else if (div_block == 0)
            start = ($urandom_range(3) != 0);
        else
            start = ($urandom_range(127) == 0); // A start that the block has to drop.
        funct3 = 3'($urandom_range(7));
        src1   = pick_operand();
        src2   = pick_operand();
    endtask

    // Starts one operation and waits until a divide no longer blocks the next one.
    task automatic issue_op(input logic [2:0] f, input logic [xlen-1:0] a,
                            input logic [xlen-1:0] b);
        start  = 1'b1;
        funct3 = f;
        src1   = a;
        src2   = b;
        @(posedge clk);
        #1;
        start = 1'b0;
        while (div_block != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic clear_scoreboard();
        exp_q.delete();
        issue_q.delete();
        lat_q.delete();
        name_q.delete();
        div_block  = 0;
        hold_valid = 1'b0;
        idle_check = 1'b1;    // Busy and done must read low at the next edge.
    endtask

    task automatic check_delivery();
        logic [xlen-1:0] expected;
        int              issued;
        int              lat;
        string           name;
        if (exp_q.size() == 0) begin
            $display("Done was high at tick %0d with no operation in flight.", tick);
            errors++;
        end else begin
            expected = exp_q.pop_front();
            issued   = issue_q.pop_front();
            lat      = lat_q.pop_front();
            name     = name_q.pop_front();
            checked++;
            if (result !== expected) begin
                $display("** Error %s: expected %h, actual %h", name, expected, result);
                errors++;
            end
            if (tick - issued != lat) begin
                $display("** Error %s latency: expected %0d, actual %0d", name, lat,
                         tick - issued);
                errors++;
            end
        end
    endtask

    task automatic finish_run(input logic timed_out);
        if (timed_out)
            $display("Watchdog expired with %0d results outstanding.", exp_q.size());
        $display("Results checked: %0d, errors: %0d", checked, errors);
        if (errors == 0 && !timed_out)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    endtask

    // ========================================================================
    // Cycle model and scoreboard, run on every rising edge
    // ========================================================================
    always @(posedge clk) begin
        logic accept;
        logic busy_exp;
        if (reset) begin
            clear_scoreboard();
        end else begin
            if (idle_check && (busy !== 1'b0 || done !== 1'b0)) begin
                $display("Busy or done was not low right after a reset or flush.");
                errors++;
            end
            idle_check = 1'b0;
            busy_exp = (div_block > 0) && (div_block < div_lat); // Load to one past done.
            if (busy !== busy_exp) begin
                $display("** Error busy at tick %0d: expected %0b, actual %0b", tick,
                         busy_exp, busy);
                errors++;
            end
            if (hold_valid && (done !== 1'b1 || result !== hold_value)) begin
                $display("Done or result changed while the block was stalled.");
                errors++;
            end
            hold_valid = stall && (done === 1'b1);
            hold_value = result;
            accept = start && !stall && !flush && (div_block == 0);
            if (!stall) begin
                tick++;
                if (div_block > 0) div_block--;
            end
            if (done === 1'b1 && !stall) check_delivery();
            if (accept) begin
                exp_q.push_back(ref_result(funct3, src1, src2));
                issue_q.push_back(tick);
                lat_q.push_back(funct3[2] ? div_lat : mul_lat); // Upper half are divides.
                name_q.push_back($sformatf("%s #%0d", op_names[funct3], accepted));
                accepted++;
                if (funct3[2]) div_block = div_lat;
            end
            if (flush) clear_scoreboard(); // Nothing in flight may complete.
        end
    end

    initial begin
        void'($urandom(32'h2421_e923));
        reset  = 1'b1;
        start  = 1'b0;
        funct3 = '0;
        src1   = '0;
        src2   = '0;
        stall  = 1'b0;
        flush  = 1'b0;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        // Signed overflow and division by zero for every divide code.
        for (int f = 4; f < 8; f++) begin
            issue_op(3'(f), 32'h8000_0000, '1);
            issue_op(3'(f), 32'h8765_4321, '0);
            issue_op(3'(f), 32'h1234_5678, '0);
        end
        while (accepted < n_ops) begin
            @(posedge clk);
            #1;
            drive_cycle();
        end
        start = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        while (exp_q.size() != 0 || div_block != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        finish_run(1'b0);
    end

    initial begin
        #(timeout_cycles * clk_period);
        finish_run(1'b1);
    end

endmodule

/* sim.f */
+incdir+include
source/rv_m_pkg.sv
source/m_op_if.sv
source/m_decode.sv
source/mul_unit.sv
source/div_unit.sv
source/m_result.sv
source/m_ext_top.sv
tb/m_ext_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= m_ext_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)
